// ==== hdl/idx_postbyte_decoder.sv ====
/*
  indexed postbyte decoder: addressing-mode routine, register and
  accumulator selects, indirection request
*/
module idx_postbyte_decoder (
    input  logic [7:0]        mdata,
    output ucode_pkg::opcat_t idx_cat,
    output logic [2:0]        idx_rsel,
    output logic [1:0]        idx_asel,
    output logic              idx_ind_bit
);
    import ucode_pkg::*;

    // mode is given by bit 7 and the low three bits
    always_comb begin
        case ({mdata[7], mdata[2:0]})
            4'b0_000: idx_cat = IDX_RINC;    // ,r+
            4'b0_010: idx_cat = IDX_RDEC;    // ,-r
            4'b0_100: idx_cat = IDX_OFFSET8; // n,r
            4'b0_110: idx_cat = IDX_R;       // ,r
            4'b0_111: idx_cat = IDX_EXT;     // extended address
            4'b1_000,
            4'b1_001,
            4'b1_111: idx_cat = IDX_ACC;     // a,r  b,r  d,r
            default:  idx_cat = BUSERROR;
        endcase
    end

    assign idx_rsel    = mdata[6:4];
    assign idx_asel    = mdata[1:0];
    assign idx_ind_bit = mdata[3];       // [ ] form

endmodule

// ==== hdl/op_categorizer.sv ====
/*
  opcode categorizer: sorts the fetched opcode into its first microcode
  routine and the routine that follows indexed address calculation
*/
module op_categorizer (
    input  logic [7:0]       op,
    output ucode_pkg::opcat_t opcat,
    output ucode_pkg::opcat_t nx_cat
);
    import ucode_pkg::*;

    opcat_t follow;  // routine run once the indexed address is ready

    always_comb begin
        follow = BUSERROR;
        case (op)
            LDA_IMM, ADDA_IMM, SUBA_IMM, ANDA_IMM,
            LDB_IMM, ADDB_IMM: begin
                opcat = SINGLE_ALU;
            end

            CLRA, INCA, DECA,
            CLRB, INCB, DECB: begin
                opcat = SINGLE_INH;
            end

            BRA, BEQ, BNE: begin
                opcat = SBRANCH;
            end

            NOP: begin
                opcat = NOPE;
            end

            // operand in indexed memory
            LDA_IDX, ADDA_IDX, LDB_IDX: begin
                opcat  = PARSE_IDX;
                follow = SINGLE_ALU_IDX;
            end

            STA, STB: begin
                opcat  = PARSE_IDX;
                follow = STORE8;
            end

            // read-modify-write on memory
            INC_IDX, DEC_IDX, CLR_IDX: begin
                opcat  = PARSE_IDX;
                follow = MEM_ALU_IDX;
            end

            default: begin
                opcat = BUSERROR;  // unknown opcode halts the CPU
            end
        endcase
    end

    // plain opcodes have no second routine
    assign nx_cat = (opcat == PARSE_IDX) ? follow : opcat;

endmodule

// ==== hdl/ucode_params.svh ====
/*
  microcode sequencer constants: ROM address split, condition-code
  bit positions and the one-hot interrupt vector codes
*/
`ifndef UCODE_PARAMS_SVH
`define UCODE_PARAMS_SVH

// microcode address = {category, step}
`define UCODE_AW 8
`define OPCAT_AW 5
`define UCODE_SW (`UCODE_AW - `OPCAT_AW)  // steps per routine, up to 8

// condition-code register mask bits
`define CC_I 4  // irq mask
`define CC_F 6  // firq mask

// one-hot interrupt codes shown on intvec
`define INT_IRQ  4'b0001
`define INT_FIRQ 4'b0010
`define INT_NMI  4'b0100
`define INT_RST  4'b1000

`endif

// ==== hdl/ucode_pkg.sv ====
/*
  microcode sequencer types: routine categories, the microinstruction
  word and the subset of opcodes the categorizer understands
*/
`include "ucode_params.svh"

package ucode_pkg;

    typedef enum logic [`OPCAT_AW-1:0] {
        RESET,
        SINGLE_ALU,
        SINGLE_INH,
        PARSE_IDX,
        SBRANCH,
        NOPE,
        MEM_ALU_IDX,    // follow-ups after the addressing routine
        SINGLE_ALU_IDX,
        STORE8,
        IDX_R,          // addressing modes
        IDX_RINC,
        IDX_RDEC,
        IDX_OFFSET8,
        IDX_ACC,
        IDX_EXT,
        IDX_IND,
        NMI,            // service routines
        FIRQ,
        IRQ,
        BUSERROR
    } opcat_t;

    typedef struct packed {
        logic ni;       // next instruction
        logic opd;      // operand fetch
        logic we;
        logic idx_en;
        logic idx_jmp;  // branch to the addressing-mode routine
        logic idx_ind;  // end of addressing mode
        logic idx_ret;  // end of indirection
        logic int_en;
        logic buserror;
    } uinst_t;

    // immediate ALU
    localparam logic [7:0] SUBA_IMM = 8'h80;
    localparam logic [7:0] ANDA_IMM = 8'h84;
    localparam logic [7:0] LDA_IMM  = 8'h86;
    localparam logic [7:0] ADDA_IMM = 8'h8b;
    localparam logic [7:0] LDB_IMM  = 8'hc6;
    localparam logic [7:0] ADDB_IMM = 8'hcb;
    // inherent
    localparam logic [7:0] DECA     = 8'h4a;
    localparam logic [7:0] INCA     = 8'h4c;
    localparam logic [7:0] CLRA     = 8'h4f;
    localparam logic [7:0] DECB     = 8'h5a;
    localparam logic [7:0] INCB     = 8'h5c;
    localparam logic [7:0] CLRB     = 8'h5f;
    // short branches and no-op
    localparam logic [7:0] NOP      = 8'h12;
    localparam logic [7:0] BRA      = 8'h20;
    localparam logic [7:0] BNE      = 8'h26;
    localparam logic [7:0] BEQ      = 8'h27;
    // indexed
    localparam logic [7:0] DEC_IDX  = 8'h6a;
    localparam logic [7:0] INC_IDX  = 8'h6c;
    localparam logic [7:0] CLR_IDX  = 8'h6f;
    localparam logic [7:0] LDA_IDX  = 8'ha6;
    localparam logic [7:0] STA      = 8'ha7;
    localparam logic [7:0] ADDA_IDX = 8'hab;
    localparam logic [7:0] LDB_IDX  = 8'he6;
    localparam logic [7:0] STB      = 8'he7;

endpackage

// ==== hdl/ucode_rom.sv ====
/*
  microcode table: each routine occupies one category row of up to
  eight steps, read through an output register
*/
`include "ucode_params.svh"

module ucode_rom (
    input  logic                 clk,
    input  logic                 cen,
    input  logic [`UCODE_AW-1:0] addr,
    output ucode_pkg::uinst_t    uinst
);
    import ucode_pkg::*;

    localparam uinst_t U_NI   = '{ni: 1'b1, default: 1'b0};
    localparam uinst_t U_OPD  = '{opd: 1'b1, default: 1'b0};
    localparam uinst_t U_WE   = '{we: 1'b1, default: 1'b0};
    localparam uinst_t U_IDX  = '{idx_en: 1'b1, default: 1'b0};
    localparam uinst_t U_JMP  = '{idx_jmp: 1'b1, default: 1'b0};
    localparam uinst_t U_IEND = '{idx_ind: 1'b1, default: 1'b0};
    localparam uinst_t U_RET  = '{idx_ret: 1'b1, default: 1'b0};
    localparam uinst_t U_INT  = '{int_en: 1'b1, default: 1'b0};
    localparam uinst_t U_BERR = '{buserror: 1'b1, default: 1'b0};

    opcat_t                cat;
    logic [`UCODE_SW-1:0]  step;
    uinst_t                word;

    assign cat  = opcat_t'(addr[`UCODE_AW-1 -: `OPCAT_AW]);
    assign step = addr[`UCODE_SW-1:0];

    always_comb begin
        word = U_BERR;  // anything not listed below halts
        case (cat)
            RESET, NMI, FIRQ, IRQ: begin
                // RESET is two steps, the interrupt services three
                if (step == 0) word = U_INT;
                if (step == 1) word = (cat == RESET) ? (U_INT | U_NI) : U_INT;
                if (step == 2 && cat != RESET) word = U_INT | U_NI;
            end
            SINGLE_ALU, SBRANCH, SINGLE_ALU_IDX: begin
                if (step == 0) word = U_OPD;
                if (step == 1) word = U_NI;
            end
            SINGLE_INH, NOPE: begin
                if (step == 0) word = U_NI;
            end
            PARSE_IDX: begin
                if (step == 0) word = U_OPD | U_JMP;  // postbyte read
            end
            IDX_R, IDX_RINC, IDX_RDEC: begin
                if (step == 0) word = U_IDX | U_IEND;
            end
            IDX_OFFSET8, IDX_EXT, IDX_ACC: begin
                if (step == 0) word = U_OPD;          // offset or address bytes
                if (step == 1) word = U_IDX | U_IEND;
            end
            IDX_IND: begin
                if (step == 0) word = U_IDX;          // fetch pointer
                if (step == 1) word = U_RET;
            end
            STORE8: begin
                if (step == 0) word = U_WE;
                if (step == 1) word = U_NI;
            end
            MEM_ALU_IDX: begin
                if (step == 0) word = U_OPD;          // read
                if (step == 1) word = U_WE;           // write back
                if (step == 2) word = U_NI;
            end
            default: begin
                word = U_BERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            uinst <= word;
        end
    end

endmodule

// ==== hdl/ucode_sequencer.sv ====
/*
  microprogram counter with interrupt arbitration at instruction
  boundaries, indexed-addressing flow and control strobe outputs
*/
`include "ucode_params.svh"

module ucode_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  ucode_pkg::opcat_t opcat,
    input  ucode_pkg::opcat_t nx_cat,
    input  ucode_pkg::opcat_t idx_cat,
    input  logic [2:0]        idx_rsel_in,
    input  logic [1:0]        idx_asel_in,
    input  logic              idx_ind_bit,
    input  logic [7:0]        cc,
    input  logic              mem_busy,
    input  logic              nmi_n,
    input  logic              firq_n,
    input  logic              irq_n,
    output logic              ni,
    output logic              opd,
    output logic              we,
    output logic              idx_en,
    output logic              int_en,
    output logic              buserror,
    output logic [3:0]        intvec,
    output logic [2:0]        idx_rsel,
    output logic [1:0]        idx_asel,
    output logic              idx_ind_rq
);
    import ucode_pkg::*;

    localparam logic [`UCODE_SW-1:0] STEP0 = '0;

    logic [`UCODE_AW-1:0] addr;
    uinst_t               uinst;
    opcat_t               nx_l;      // follow-up of the current opcode
    logic                 bubble;    // rom word in flight after a jump is void
    logic                 advance;
    logic                 idx_jmp, idx_ind, idx_ret;
    logic                 nmin_l, do_nmi;
    logic                 take_firq, take_irq;
    logic [3:0]           cur_int;

    ucode_rom u_rom (
        .clk   (clk),
        .cen   (advance),  // rom word holds during stalls
        .addr  (addr),
        .uinst (uinst)
    );

    assign ni       = uinst.ni       & ~bubble;
    assign opd      = uinst.opd      & ~bubble;
    assign we       = uinst.we       & ~bubble;
    assign idx_en   = uinst.idx_en   & ~bubble;
    assign int_en   = uinst.int_en   & ~bubble;
    assign buserror = uinst.buserror & ~bubble;
    assign idx_jmp  = uinst.idx_jmp  & ~bubble;
    assign idx_ind  = uinst.idx_ind  & ~bubble;
    assign idx_ret  = uinst.idx_ret  & ~bubble;

    assign intvec = cur_int & {4{int_en}};

    // bus error halts everything until reset
    assign advance = cen & ~mem_busy & ~buserror;

    assign take_firq = ~firq_n & ~cc[`CC_F];  // level triggered
    assign take_irq  = ~irq_n  & ~cc[`CC_I];

    // nmi is edge triggered, pending until the next ni
    always_ff @(posedge clk) begin
        if (rst) begin
            nmin_l <= 1'b0;
            do_nmi <= 1'b0;
        end else if (cen) begin
            nmin_l <= nmi_n;
            if (nmin_l && !nmi_n) begin
                do_nmi <= 1'b1;
            end else if (advance && ni && do_nmi) begin
                do_nmi <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr       <= {RESET, STEP0};
            bubble     <= 1'b1;
            cur_int    <= `INT_RST;
            nx_l       <= RESET;
            idx_rsel   <= '0;
            idx_asel   <= '0;
            idx_ind_rq <= 1'b0;
        end else if (advance) begin
            addr   <= addr + 1'b1;  // next step of the routine
            bubble <= 1'b0;
            if (ni) begin
                bubble <= 1'b1;
                nx_l   <= nx_cat;
                if (do_nmi) begin
                    cur_int <= `INT_NMI;
                    addr    <= {NMI, STEP0};
                end else if (take_firq) begin
                    cur_int <= `INT_FIRQ;
                    addr    <= {FIRQ, STEP0};
                end else if (take_irq) begin
                    cur_int <= `INT_IRQ;
                    addr    <= {IRQ, STEP0};
                end else begin
                    cur_int <= '0;
                    addr    <= {opcat, STEP0};  // new opcode
                end
            end
            // postbyte is on mdata during this step
            if (idx_jmp) begin
                bubble     <= 1'b1;
                addr       <= {idx_cat, STEP0};
                idx_rsel   <= idx_rsel_in;
                idx_asel   <= idx_asel_in;
                idx_ind_rq <= idx_ind_bit;
            end
            if (idx_ind) begin
                bubble <= 1'b1;
                addr   <= idx_ind_rq ? {IDX_IND, STEP0} : {nx_l, STEP0};
            end
            if (idx_ret) begin
                bubble     <= 1'b1;
                idx_ind_rq <= 1'b0;
                addr       <= {nx_l, STEP0};
            end
        end
    end

endmodule

// ==== hdl/ucode_top.sv ====
/*
  microcode sequencer top: opcode and postbyte decoders feeding
  the sequencer
*/
module ucode_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] op,
    input  logic [7:0] mdata,
    input  logic [7:0] cc,
    input  logic       mem_busy,
    input  logic       nmi_n,
    input  logic       firq_n,
    input  logic       irq_n,
    output logic       ni,
    output logic       opd,
    output logic       we,
    output logic       idx_en,
    output logic       int_en,
    output logic       buserror,
    output logic [3:0] intvec,
    output logic [2:0] idx_rsel,
    output logic [1:0] idx_asel,
    output logic       idx_ind_rq
);
    import ucode_pkg::*;

    opcat_t     opcat, nx_cat, idx_cat;
    logic [2:0] post_rsel;
    logic [1:0] post_asel;
    logic       post_ind;

    op_categorizer u_cat (
        .op     (op),
        .opcat  (opcat),
        .nx_cat (nx_cat)
    );

    idx_postbyte_decoder u_post (
        .mdata       (mdata),
        .idx_cat     (idx_cat),
        .idx_rsel    (post_rsel),
        .idx_asel    (post_asel),
        .idx_ind_bit (post_ind)
    );

    ucode_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .opcat       (opcat),
        .nx_cat      (nx_cat),
        .idx_cat     (idx_cat),
        .idx_rsel_in (post_rsel),
        .idx_asel_in (post_asel),
        .idx_ind_bit (post_ind),
        .cc          (cc),
        .mem_busy    (mem_busy),
        .nmi_n       (nmi_n),
        .firq_n      (firq_n),
        .irq_n       (irq_n),
        .ni          (ni),
        .opd         (opd),
        .we          (we),
        .idx_en      (idx_en),
        .int_en      (int_en),
        .buserror    (buserror),
        .intvec      (intvec),
        .idx_rsel    (idx_rsel),
        .idx_asel    (idx_asel),
        .idx_ind_rq  (idx_ind_rq)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the microcode sequencer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ucode_tb -o ucode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/ucode_sim 2>&1)
status=$?
echo "$sim_out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== tb/ucode_props.sv ====
/*
  sequencer properties: strobe exclusion, vector qualification,
  bus error hold and stall stability
*/
module ucode_props (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic       mem_busy,
    input logic       ni,
    input logic       opd,
    input logic       we,
    input logic       idx_en,
    input logic       int_en,
    input logic       buserror,
    input logic [3:0] intvec
);
    timeunit 1ns;
    timeprecision 100ps;

    a_ni_berr: assert property (@(posedge clk) !(ni && buserror))
        else $error("ni and buserror high in the same cycle");

    // one code during a service routine, nothing outside it
    a_vec: assert property (@(posedge clk)
        int_en ? $onehot(intvec) : (intvec == 4'b0000))
        else $error("intvec not one-hot during service or nonzero outside it");

    // halted until the next reset
    a_berr_hold: assert property (@(posedge clk) (buserror && !rst) |=> (buserror || rst))
        else $error("buserror dropped without reset");

    a_stall: assert property (@(posedge clk)
        (cen && mem_busy && !rst) |=> (rst || $stable({ni, opd, we, idx_en, int_en})))
        else $error("strobes changed during a memory stall");

endmodule

bind ucode_sequencer ucode_props u_props (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .mem_busy (mem_busy),
    .ni       (ni),
    .opd      (opd),
    .we       (we),
    .idx_en   (idx_en),
    .int_en   (int_en),
    .buserror (buserror),
    .intvec   (intvec)
);

// ==== tb/ucode_tb.sv ====
/*
  directed testbench for the microcode sequencer: single opcodes,
  indexed modes, interrupts, stalls and bus error
*/
`include "ucode_params.svh"

module ucode_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ucode_pkg::*;

    logic clk = 1'b0;
    logic rst, cen, mem_busy, nmi_n, firq_n, irq_n;
    logic [7:0] op, mdata, cc;
    logic ni, opd, we, idx_en, int_en, buserror, idx_ind_rq;
    logic [3:0] intvec;
    logic [2:0] idx_rsel;
    logic [1:0] idx_asel;

    int errors = 0;
    int timeouts = 0;
    int cyc, n_opd, n_we, n_idx, n_int;  // per-routine tallies
    logic [3:0] vec;
    logic rq_seen, stall_mode, hold_nmi;

    ucode_top UUT (.*);

    always #4 clk = ~clk;  // 8 ns period

    task automatic check_val(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // runs one routine from a boundary until the next ni, skipping stalled cycles
    task automatic measure_routine();
        int guard;
        logic busy, done;
        guard = 0;
        done = 1'b0;
        {cyc, n_opd, n_we, n_idx, n_int} = '0;
        vec = 4'b0000;
        rq_seen = 1'b0;
        while (!done && guard < 200) begin
            @(posedge clk);
            #1;
            guard++;
            if (guard == 1) begin  // lines were sampled at the boundary
                firq_n = 1'b1;
                irq_n = 1'b1;
                if (!hold_nmi) nmi_n = 1'b1;
            end
            busy = stall_mode && ($urandom_range(3) == 0);
            mem_busy = busy;
            cen = !(stall_mode && ($urandom_range(7) == 0));
            if (!busy && cen) begin
                cyc++;
                n_opd += opd;
                n_we += we;
                n_idx += idx_en;
                n_int += int_en;
                if (int_en) vec = intvec;
                if (idx_ind_rq) rq_seen = 1'b1;
                if (ni) done = 1'b1;
            end
        end
        mem_busy = 1'b0;
        cen = 1'b1;
        if (!done) begin
            timeouts++;
            $display("timeout at %0t: routine never reached ni", $time);
        end
    endtask

    task automatic wait_for_ni();
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            #1;
            guard++;
        end while (!ni && guard < 100);
        if (!ni) begin
            timeouts++;
            $display("timeout at %0t: no ni seen", $time);
        end
    endtask

    task automatic run_op(input logic [7:0] o, input int steps, input int nopd);
        op = o;
        measure_routine();
        check_val($sformatf("cycles of op %h", o), cyc, 1 + steps);  // bubble + steps
        check_val($sformatf("opd of op %h", o), n_opd, nopd);
        check_val("we count", n_we, 0);
        check_val("idx_en count", n_idx, 0);
        check_val("int_en count", n_int, 0);
    endtask

    function automatic int mode_steps(input logic [7:0] md);
        if (!md[7]) begin
            case (md[2:0])
                3'b000, 3'b010, 3'b110: return 1;
                3'b100, 3'b111: return 2;
                default: return 0;
            endcase
        end
        if (md[2:0] == 3'b000 || md[2:0] == 3'b001 || md[2:0] == 3'b111) return 2;
        return 0;
    endfunction

    task automatic run_idx(input logic [7:0] o, input logic [7:0] md);
        int ms, fs, f_opd, f_we;
        ms = mode_steps(md);
        f_we = (o == STA || o == STB || o == INC_IDX || o == DEC_IDX || o == CLR_IDX);
        f_opd = (o != STA && o != STB);
        fs = (o == INC_IDX || o == DEC_IDX || o == CLR_IDX) ? 3 : 2;
        op = o;
        mdata = md;
        measure_routine();
        check_val($sformatf("cycles of %h/%h", o, md), cyc,
                  2 + (1 + ms) + (md[3] ? 3 : 0) + (1 + fs));
        check_val("indexed opd count", n_opd, 1 + (ms == 2) + f_opd);
        check_val("indexed we count", n_we, f_we);
        check_val("indexed idx_en count", n_idx, 1 + md[3]);
        check_val("idx_rsel", idx_rsel, md[6:4]);
        check_val("idx_asel", idx_asel, md[1:0]);
        check_val("idx_ind_rq seen", rq_seen, md[3]);
        check_val("idx_ind_rq after", idx_ind_rq, 0);
    endtask

    // reset routine shows int_en with the reset code, then ni
    task automatic apply_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        op = NOP;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        measure_routine();
        check_val("reset cycles", cyc, 2);
        check_val("reset int_en count", n_int, 2);
        check_val("reset intvec", vec, `INT_RST);
    endtask

    task automatic irq_case(input logic n, input logic f, input logic i,
                            input logic [7:0] ccv, input logic [3:0] exp_vec,
                            input logic hold);
        op = LDA_IMM;
        @(posedge clk);
        #1;
        nmi_n = n;
        firq_n = f;
        irq_n = i;
        cc = ccv;
        wait_for_ni();
        op = NOP;
        hold_nmi = hold;
        measure_routine();
        check_val("cycles after ni", cyc, (exp_vec != 0) ? 4 : 2);
        check_val("service int_en count", n_int, (exp_vec != 0) ? 3 : 0);
        check_val("intvec", vec, exp_vec);
        if (hold) begin
            run_op(NOP, 1, 0);  // low level alone is no new edge
            nmi_n = 1'b1;
            hold_nmi = 1'b0;
        end
    endtask

    task automatic bus_error_case(input logic [7:0] o, input logic [7:0] md);
        int guard;
        op = o;
        mdata = md;
        guard = 0;
        do begin
            @(posedge clk);
            #1;
            guard++;
        end while (!buserror && guard < 50);
        if (!buserror) begin
            timeouts++;
            $display("timeout at %0t: buserror never raised", $time);
        end
        op = NOP;
        repeat (10) begin
            @(posedge clk);
            #1;
            check_val("buserror held", buserror, 1);
            check_val("ni while halted", ni, 0);
        end
        apply_reset();
        run_op(NOP, 1, 0);
    endtask

    initial begin
        void'($urandom(32'h66c3));
        rst = 1'b1;
        cen = 1'b1;
        op = NOP;
        mdata = 8'h00;
        cc = 8'h00;
        mem_busy = 1'b0;
        {nmi_n, firq_n, irq_n} = 3'b111;
        stall_mode = 1'b0;
        hold_nmi = 1'b0;
        apply_reset();

        // single routines, steps and opd from the length table
        run_op(LDA_IMM, 2, 1);
        run_op(ADDA_IMM, 2, 1);
        run_op(CLRA, 1, 0);
        run_op(INCB, 1, 0);
        run_op(BRA, 2, 1);
        run_op(BEQ, 2, 1);
        run_op(NOP, 1, 0);

        // indexed modes without and with indirection
        run_idx(LDA_IDX, 8'h06);
        run_idx(STA, 8'h10);
        run_idx(INC_IDX, 8'h22);
        run_idx(LDA_IDX, 8'h34);
        run_idx(STA, 8'h47);
        run_idx(INC_IDX, 8'hd1);
        run_idx(LDA_IDX, 8'hf7);
        run_idx(LDA_IDX, 8'h1e);
        run_idx(STA, 8'h9f);
        run_idx(INC_IDX, 8'h2c);

        irq_case(1'b0, 1'b0, 1'b0, 8'h00, `INT_NMI, 1'b0);
        irq_case(1'b1, 1'b0, 1'b0, 8'h00, `INT_FIRQ, 1'b0);
        irq_case(1'b1, 1'b0, 1'b0, 8'h40, `INT_IRQ, 1'b0);  // firq masked
        irq_case(1'b1, 1'b1, 1'b0, 8'h10, 4'b0000, 1'b0);
        irq_case(1'b1, 1'b0, 1'b1, 8'h50, 4'b0000, 1'b0);
        irq_case(1'b1, 1'b1, 1'b0, 8'h00, `INT_IRQ, 1'b0);
        irq_case(1'b0, 1'b1, 1'b1, 8'h50, `INT_NMI, 1'b1);  // nmi ignores masks
        cc = 8'h00;

        stall_mode = 1'b1;
        run_op(LDA_IMM, 2, 1);
        run_op(CLRB, 1, 0);
        run_idx(INC_IDX, 8'h34);
        run_idx(STA, 8'h9f);
        run_idx(LDA_IDX, 8'h2c);
        stall_mode = 1'b0;

        bus_error_case(8'hff, 8'h00);  // unknown opcode
        bus_error_case(LDA_IDX, 8'h82);  // bad postbyte

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/ucode_pkg.sv
hdl/op_categorizer.sv
hdl/idx_postbyte_decoder.sv
hdl/ucode_rom.sv
hdl/ucode_sequencer.sv
hdl/ucode_top.sv
tb/ucode_props.sv
tb/ucode_tb.sv
